//--- rtl/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// ====================
// Execute stage sizes
// ====================

// Data and address width.
`define EXEC_XLEN 32

// Operation-number width.
`define EXEC_OP_W 6

// Multiply/divide iterations, one bit each.
`define EXEC_MD_STEPS 32

`endif

//--- rtl/exec_pkg.sv
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

	// Instruction category, decoded from the operation number.
	typedef enum logic [2:0] {
		CAT_IDLE,
		CAT_NOP,
		CAT_ALU,
		CAT_MULDIV,
		CAT_MEM,
		CAT_BRANCH
	} exec_cat_e;

	// ====================
	// Operation numbers
	// ====================
	localparam logic [`EXEC_OP_W-1:0] OP_ADD  = 8;
	localparam logic [`EXEC_OP_W-1:0] OP_ADDI = 9;
	localparam logic [`EXEC_OP_W-1:0] OP_SUB  = 10;
	localparam logic [`EXEC_OP_W-1:0] OP_SLT  = 11; // Signed.
	localparam logic [`EXEC_OP_W-1:0] OP_MUL  = 12;
	localparam logic [`EXEC_OP_W-1:0] OP_DIVU = 13;
	localparam logic [`EXEC_OP_W-1:0] OP_AND  = 16;
	localparam logic [`EXEC_OP_W-1:0] OP_OR   = 17;
	localparam logic [`EXEC_OP_W-1:0] OP_XOR  = 18;
	localparam logic [`EXEC_OP_W-1:0] OP_ANDI = 19;
	localparam logic [`EXEC_OP_W-1:0] OP_ORI  = 20;
	localparam logic [`EXEC_OP_W-1:0] OP_SLL  = 21;
	localparam logic [`EXEC_OP_W-1:0] OP_SRL  = 22;
	localparam logic [`EXEC_OP_W-1:0] OP_SRA  = 23;
	localparam logic [`EXEC_OP_W-1:0] OP_LW   = 28;
	localparam logic [`EXEC_OP_W-1:0] OP_SW   = 29;
	localparam logic [`EXEC_OP_W-1:0] OP_BEQ  = 32;
	localparam logic [`EXEC_OP_W-1:0] OP_BNE  = 33;
	localparam logic [`EXEC_OP_W-1:0] OP_J    = 34;
	localparam logic [`EXEC_OP_W-1:0] OP_JAL  = 35;
	localparam logic [`EXEC_OP_W-1:0] OP_JR   = 36;

	// Sequential pc increment.
	localparam logic [`EXEC_XLEN-1:0] PC_STEP = 4;

endpackage

`default_nettype wire

//--- rtl/step_counter.sv
`default_nettype none

module step_counter #(
	parameter int WIDTH = 6
) (
	input wire clk,
	input wire rst_n,
	input wire load,
	input wire [WIDTH-1:0] load_value,
	input wire step,
	output logic last,
	output logic busy
);

	logic [WIDTH-1:0] count;

	assign busy = (count != '0);
	assign last = (count == WIDTH'(1)); // Final step pending.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			count <= '0;
		else if (load)
			count <= load_value;
		else if (step && busy)
			count <= count - 1'b1;
	end

	a_no_reload: assert property (@(posedge clk) disable iff (!rst_n) load |-> !busy)
		else $error("step counter reloaded while busy");

endmodule

`default_nettype wire

//--- rtl/alu_elem.sv
`default_nettype none

`include "exec_cfg.svh"

module alu_elem
	import exec_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire active,
	input wire [`EXEC_OP_W-1:0] inst_num,
	input wire [`EXEC_XLEN-1:0] rs,
	input wire [`EXEC_XLEN-1:0] rt,
	input wire [`EXEC_XLEN-1:0] const16_x,
	input wire [4:0] shift5,
	output logic completed,
	output logic [`EXEC_XLEN-1:0] out
);

	logic [`EXEC_XLEN-1:0] result;
	logic [`EXEC_XLEN-1:0] imm_z;
	logic done;

	assign imm_z = {{(`EXEC_XLEN-16){1'b0}}, const16_x[15:0]};

	always_comb begin
		result = '0; // 24 to 27 fall through.
		case (inst_num)
			OP_ADD:  result = rs + rt;
			OP_ADDI: result = rs + const16_x;
			OP_SUB:  result = rs - rt;
			OP_SLT:  result[0] = $signed(rs) < $signed(rt);
			OP_AND:  result = rs & rt;
			OP_OR:   result = rs | rt;
			OP_XOR:  result = rs ^ rt;
			OP_ANDI: result = rs & imm_z;
			OP_ORI:  result = rs | imm_z;
			OP_SLL:  result = rt << shift5;
			OP_SRL:  result = rt >> shift5;
			OP_SRA:  result = $signed(rt) >>> shift5;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
			completed <= 1'b0;
		end else begin
			completed <= active && !done; // One pulse per activation.
			done <= active;
		end
	end

	always_ff @(posedge clk) begin
		if (active && !done)
			out <= result;
	end

endmodule

`default_nettype wire

//--- rtl/muldiv_elem.sv
`default_nettype none

`include "exec_cfg.svh"

module muldiv_elem
	import exec_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire active,
	input wire [`EXEC_OP_W-1:0] inst_num,
	input wire [`EXEC_XLEN-1:0] rs,
	input wire [`EXEC_XLEN-1:0] rt,
	output logic completed,
	output logic [`EXEC_XLEN-1:0] out
);

	localparam int CNT_W = $clog2(`EXEC_MD_STEPS + 1);

	logic started;
	logic is_div;
	logic cnt_load, cnt_step, cnt_last, cnt_busy;
	logic [`EXEC_XLEN-1:0] acc;  // Product.
	logic [`EXEC_XLEN-1:0] opa;  // Multiplicand, or dividend turning into quotient.
	logic [`EXEC_XLEN-1:0] opb;  // Multiplier, or divisor.
	logic [`EXEC_XLEN-1:0] rem;
	logic [`EXEC_XLEN:0] shifted;

	assign cnt_load = active && !started;
	assign cnt_step = cnt_busy;
	assign shifted = {rem, opa[`EXEC_XLEN-1]};
	assign out = is_div ? opa : acc;

	step_counter #(.WIDTH(CNT_W)) u_steps (
		.clk, .rst_n,
		.load(cnt_load),
		.load_value(CNT_W'(`EXEC_MD_STEPS)),
		.step(cnt_step),
		.last(cnt_last),
		.busy(cnt_busy)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			started <= 1'b0;
			completed <= 1'b0;
			is_div <= 1'b0;
		end else begin
			started <= active;
			completed <= cnt_step && cnt_last;
			if (cnt_load)
				is_div <= (inst_num == OP_DIVU);
		end
	end

	// ====================
	// One bit per step
	// ====================
	always_ff @(posedge clk) begin
		if (cnt_load) begin
			acc <= '0;
			rem <= '0;
			opa <= rs;
			opb <= rt;
		end else if (cnt_step) begin
			if (is_div) begin
				// Zero divisor always subtracts, so the quotient ends all ones.
				if (shifted >= {1'b0, opb}) begin
					rem <= shifted[`EXEC_XLEN-1:0] - opb;
					opa <= {opa[`EXEC_XLEN-2:0], 1'b1};
				end else begin
					rem <= shifted[`EXEC_XLEN-1:0];
					opa <= {opa[`EXEC_XLEN-2:0], 1'b0};
				end
			end else begin
				if (opb[0])
					acc <= acc + opa;
				opa <= opa << 1;
				opb <= opb >> 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/mem_elem.sv
`default_nettype none

`include "exec_cfg.svh"

module mem_elem (
	input wire clk,
	input wire rst_n,
	input wire active,
	input wire [`EXEC_OP_W-1:0] inst_num,
	input wire [`EXEC_XLEN-1:0] rs,
	input wire [`EXEC_XLEN-1:0] rt,
	input wire [`EXEC_XLEN-1:0] const16_x,
	output logic completed,
	output logic [`EXEC_XLEN-1:0] out,
	output logic [`EXEC_XLEN-1:0] main_mem_in_addr,
	output logic [`EXEC_XLEN-1:0] main_mem_in_data,
	output logic main_mem_in_valid,
	input wire main_mem_in_ready,
	output logic [`EXEC_XLEN-1:0] main_mem_out_addr,
	output logic main_mem_out_valid,
	input wire [`EXEC_XLEN-1:0] main_mem_out_data,
	input wire main_mem_out_ready
);

	typedef enum logic [1:0] {IDLE, REQ, DONE} state_e;

	state_e state;
	logic is_store;
	logic xfer;
	logic [`EXEC_XLEN-1:0] addr;
	logic [`EXEC_XLEN-1:0] wdata;

	assign main_mem_in_valid  = (state == REQ) && is_store;
	assign main_mem_out_valid = (state == REQ) && !is_store;
	assign main_mem_in_addr  = addr;
	assign main_mem_in_data  = wdata;
	assign main_mem_out_addr = addr;
	assign xfer = is_store ? main_mem_in_ready : main_mem_out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			completed <= 1'b0;
		end else begin
			completed <= 1'b0;
			case (state)
				IDLE: if (active) state <= REQ;
				REQ: begin
					if (!active)
						state <= IDLE;
					else if (xfer) begin
						state <= DONE;
						completed <= 1'b1;
					end
				end
				default: if (!active) state <= IDLE; // Hold result.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && active) begin
			addr <= rs + const16_x;
			wdata <= rt;
			is_store <= inst_num[0]; // 29 and 31 store.
			out <= '0;
		end else if (main_mem_out_valid && main_mem_out_ready) begin
			out <= main_mem_out_data;
		end
	end

	a_one_valid: assert property (@(posedge clk) disable iff (!rst_n)
		!(main_mem_in_valid && main_mem_out_valid))
		else $error("store and load valid together");

	a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		main_mem_in_valid && !main_mem_in_ready |=>
		main_mem_in_valid && $stable(main_mem_in_addr))
		else $error("store request dropped before ready");

	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		main_mem_out_valid && !main_mem_out_ready |=>
		main_mem_out_valid && $stable(main_mem_out_addr))
		else $error("load request dropped before ready");

endmodule

`default_nettype wire

//--- rtl/branch_elem.sv
`default_nettype none

`include "exec_cfg.svh"

module branch_elem
	import exec_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire active,
	input wire [`EXEC_OP_W-1:0] inst_num,
	input wire [`EXEC_XLEN-1:0] pc,
	input wire [`EXEC_XLEN-1:0] rs,
	input wire [`EXEC_XLEN-1:0] rt,
	input wire [`EXEC_XLEN-1:0] const16_x,
	input wire [25:0] addr26,
	output logic completed,
	output logic [`EXEC_XLEN-1:0] reg_out,
	output logic [`EXEC_XLEN-1:0] pc_out
);

	logic done;
	logic [`EXEC_XLEN-1:0] pc4, br_target, j_target, next_pc, link;

	assign pc4 = pc + PC_STEP;
	assign br_target = pc4 + {const16_x[`EXEC_XLEN-3:0], 2'b00};
	assign j_target = {pc4[`EXEC_XLEN-1:`EXEC_XLEN-4], addr26, 2'b00};

	always_comb begin
		next_pc = pc4;
		link = '0;
		case (inst_num)
			OP_BEQ: if (rs == rt) next_pc = br_target;
			OP_BNE: if (rs != rt) next_pc = br_target;
			OP_J:   next_pc = j_target;
			OP_JAL: begin
				next_pc = j_target;
				link = pc4; // Return address.
			end
			OP_JR:  next_pc = rs;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
			completed <= 1'b0;
		end else begin
			completed <= active && !done;
			done <= active;
		end
	end

	always_ff @(posedge clk) begin
		if (active && !done) begin
			pc_out <= next_pc;
			reg_out <= link;
		end
	end

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`default_nettype none

`include "exec_cfg.svh"

module exec_unit
	import exec_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire [`EXEC_XLEN-1:0] pc,
	input wire [`EXEC_OP_W-1:0] inst_num,
	input wire [15:0] const16,
	input wire [4:0] shift5,
	input wire [25:0] addr26,
	input wire [`EXEC_XLEN-1:0] rs,
	input wire [`EXEC_XLEN-1:0] rt,
	output logic completed,
	output logic [`EXEC_XLEN-1:0] exec_reg_out,
	output logic [`EXEC_XLEN-1:0] exec_pc_out,
	output logic [`EXEC_XLEN-1:0] main_mem_in_addr,
	output logic [`EXEC_XLEN-1:0] main_mem_in_data,
	output logic main_mem_in_valid,
	input wire main_mem_in_ready,
	output logic [`EXEC_XLEN-1:0] main_mem_out_addr,
	output logic main_mem_out_valid,
	input wire [`EXEC_XLEN-1:0] main_mem_out_data,
	input wire main_mem_out_ready
);

	exec_cat_e cat;
	logic [`EXEC_XLEN-1:0] const16_x;
	logic alu_active, md_active, mem_active, br_active;
	logic alu_done, md_done, mem_done, br_done;
	logic [`EXEC_XLEN-1:0] alu_out, md_out, mem_out, br_reg_out, br_pc_out;
	logic nop_seen;
	logic nop_done;

	// ====================
	// Category decode
	// ====================
	always_comb begin
		if (inst_num < 6'd4)
			cat = CAT_IDLE;
		else if ((inst_num >= 6'd8 && inst_num < 6'd12) || (inst_num >= 6'd16 && inst_num < 6'd28))
			cat = CAT_ALU;
		else if (inst_num == OP_MUL || inst_num == OP_DIVU)
			cat = CAT_MULDIV;
		else if (inst_num >= 6'd28 && inst_num < 6'd32)
			cat = CAT_MEM;
		else if (inst_num >= 6'd32 && inst_num < 6'd48)
			cat = CAT_BRANCH;
		else
			cat = CAT_NOP; // Misc and float ranges.
	end

	assign const16_x = {{(`EXEC_XLEN-16){const16[15]}}, const16};

	assign alu_active = (cat == CAT_ALU);
	assign md_active  = (cat == CAT_MULDIV);
	assign mem_active = (cat == CAT_MEM);
	assign br_active  = (cat == CAT_BRANCH);

	alu_elem u_alu (
		.clk, .rst_n, .active(alu_active), .inst_num, .rs, .rt, .const16_x, .shift5,
		.completed(alu_done), .out(alu_out)
	);

	muldiv_elem u_muldiv (
		.clk, .rst_n, .active(md_active), .inst_num, .rs, .rt,
		.completed(md_done), .out(md_out)
	);

	mem_elem u_mem (
		.clk, .rst_n, .active(mem_active), .inst_num, .rs, .rt, .const16_x,
		.completed(mem_done), .out(mem_out),
		.main_mem_in_addr, .main_mem_in_data, .main_mem_in_valid, .main_mem_in_ready,
		.main_mem_out_addr, .main_mem_out_valid, .main_mem_out_data, .main_mem_out_ready
	);

	branch_elem u_branch (
		.clk, .rst_n, .active(br_active), .inst_num, .pc, .rs, .rt, .const16_x, .addr26,
		.completed(br_done), .reg_out(br_reg_out), .pc_out(br_pc_out)
	);

	// No-op completes one cycle after issue.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			nop_seen <= 1'b0;
			nop_done <= 1'b0;
		end else begin
			nop_done <= (cat == CAT_NOP) && !nop_seen;
			nop_seen <= (cat == CAT_NOP);
		end
	end

	// ====================
	// Result merge
	// ====================
	assign completed = alu_done | md_done | mem_done | br_done | nop_done;

	always_comb begin
		case (cat)
			CAT_ALU:    exec_reg_out = alu_out;
			CAT_MULDIV: exec_reg_out = md_out;
			CAT_MEM:    exec_reg_out = mem_out;
			CAT_BRANCH: exec_reg_out = br_reg_out;
			default:    exec_reg_out = '0;
		endcase
	end

	assign exec_pc_out = (cat == CAT_BRANCH) ? br_pc_out : pc + PC_STEP;

	a_one_done: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({alu_done, md_done, mem_done, br_done, nop_done}))
		else $error("more than one element completed");

endmodule

`default_nettype wire

//--- tb/exec_unit_tb.sv
`default_nettype none

`include "exec_cfg.svh"

module exec_unit_tb
	import exec_pkg::*;
();

	localparam int N_INSTR = 48 + 13 + 12 + 9 + 8;
	localparam int WATCHDOG_CYCLES = N_INSTR * 60;

	logic clk;
	logic rst_n;
	logic [`EXEC_XLEN-1:0] pc;
	logic [`EXEC_OP_W-1:0] inst_num;
	logic [15:0] const16;
	logic [4:0] shift5;
	logic [25:0] addr26;
	logic [`EXEC_XLEN-1:0] rs, rt;
	logic completed;
	logic [`EXEC_XLEN-1:0] exec_reg_out, exec_pc_out;
	logic [`EXEC_XLEN-1:0] main_mem_in_addr, main_mem_in_data, main_mem_out_addr;
	logic main_mem_in_valid, main_mem_out_valid;
	logic main_mem_in_ready = 1'b0;
	logic main_mem_out_ready = 1'b0;
	logic [`EXEC_XLEN-1:0] main_mem_out_data = '0;

	integer seed = 60030;
	logic [`EXEC_XLEN-1:0] mem_model [256];
	logic [`EXEC_XLEN-1:0] ref_mem [256]; // Expected memory contents.
	logic [`EXEC_XLEN-1:0] exp_reg = '0;
	logic [`EXEC_XLEN-1:0] exp_pc = '0;
	logic [`EXEC_XLEN-1:0] exp_addr = '0;
	logic [`EXEC_XLEN-1:0] exp_wdata = '0;
	int exp_lat = 1;
	int cycles = 0;
	int issue_cyc = 0;
	logic issued_once = 1'b0;
	int errors = 0;
	int err_mark = 0;
	int n_tests = 0;
	int n_instr = 0;

	exec_unit DUT (
		.clk, .rst_n, .pc, .inst_num, .const16, .shift5, .addr26, .rs, .rt,
		.completed, .exec_reg_out, .exec_pc_out,
		.main_mem_in_addr, .main_mem_in_data, .main_mem_in_valid, .main_mem_in_ready,
		.main_mem_out_addr, .main_mem_out_valid, .main_mem_out_data, .main_mem_out_ready
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		forever begin
			@(posedge clk);
			cycles++;
		end
	end

	// ====================
	// Helpers and model
	// ====================
	function automatic logic [`EXEC_XLEN-1:0] next_rand();
		return $random(seed);
	endfunction

	function automatic logic [`EXEC_XLEN-1:0] rand_pc();
		return next_rand() & 32'hffff_fffc;
	endfunction

	function automatic logic [`EXEC_XLEN-1:0] sign_ext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic logic [`EXEC_XLEN-1:0] expected_result(input logic [5:0] op,
			input logic [31:0] a, input logic [31:0] b, input logic [15:0] imm,
			input logic [4:0] sh, input logic [31:0] pc_v);
		case (op)
			OP_ADD:  return a + b;
			OP_ADDI: return a + sign_ext16(imm);
			OP_SUB:  return a - b;
			OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_MUL:  return a * b;
			OP_DIVU: return (b == 32'd0) ? 32'hffff_ffff : a / b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_ANDI: return a & {16'h0000, imm};
			OP_ORI:  return a | {16'h0000, imm};
			OP_SLL:  return b << sh;
			OP_SRL:  return b >> sh;
			OP_SRA:  return $signed(b) >>> sh;
			OP_JAL:  return pc_v + 32'd4; // Link.
			default: return '0;
		endcase
	endfunction

	function automatic logic [`EXEC_XLEN-1:0] expected_pc(input logic [5:0] op,
			input logic [31:0] a, input logic [31:0] b, input logic [15:0] imm,
			input logic [25:0] jf, input logic [31:0] pc_v);
		logic [31:0] pc4;
		pc4 = pc_v + 32'd4;
		case (op)
			OP_BEQ:       return (a == b) ? pc4 + (sign_ext16(imm) << 2) : pc4;
			OP_BNE:       return (a != b) ? pc4 + (sign_ext16(imm) << 2) : pc4;
			OP_J, OP_JAL: return {pc4[31:28], jf, 2'b00};
			OP_JR:        return a;
			default:      return pc4;
		endcase
	endfunction

	// Zero stands for a memory wait of 2 cycles or more.
	function automatic int expected_latency(input logic [5:0] op);
		if (op == OP_MUL || op == OP_DIVU)
			return `EXEC_MD_STEPS + 1;
		if (op >= 6'd28 && op < 6'd32)
			return 0;
		return 1;
	endfunction

	task automatic value_mismatch(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic protocol_error(input string msg);
		$display("Memory port or completion misbehaved at time %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic issue(input logic [5:0] op, input logic [31:0] a, input logic [31:0] b,
			input logic [15:0] imm, input logic [4:0] sh, input logic [25:0] jf,
			input logic [31:0] pc_v);
		logic [31:0] addr;
		addr = a + sign_ext16(imm);
		@(negedge clk);
		inst_num = op;
		rs = a;
		rt = b;
		const16 = imm;
		shift5 = sh;
		addr26 = jf;
		pc = pc_v;
		exp_reg = expected_result(op, a, b, imm, sh, pc_v);
		exp_addr = addr;
		exp_wdata = b;
		if (op >= 6'd28 && op < 6'd32) begin
			if (op[0])
				ref_mem[addr[9:2]] = b;
			else
				exp_reg = ref_mem[addr[9:2]]; // Load returns the stored word.
		end
		exp_pc = expected_pc(op, a, b, imm, jf, pc_v);
		exp_lat = expected_latency(op);
		issue_cyc = cycles;
		issued_once = 1'b1;
		n_instr++;
		do @(negedge clk); while (!completed);
		inst_num = 6'(next_rand() % 4);
		@(negedge clk);
	endtask

	task automatic finish_test(input string name);
		if (errors == err_mark)
			$display("Test %0d %s: passed", n_tests + 1, name);
		else
			$display("Test %0d %s: %0d errors", n_tests + 1, name, errors - err_mark);
		n_tests++;
		err_mark = errors;
	endtask

	// ====================
	// Memory model
	// ====================
	initial begin
		for (int i = 0; i < 256; i++) begin
			mem_model[i] = 32'hc3a5_0000 ^ (i * 32'h0001_0203);
			ref_mem[i] = 32'hc3a5_0000 ^ (i * 32'h0001_0203);
		end
		forever begin
			@(posedge clk);
			if (main_mem_in_valid && main_mem_in_ready)
				mem_model[main_mem_in_addr[9:2]] = main_mem_in_data;
		end
	end

	initial begin
		forever begin
			@(negedge clk);
			main_mem_in_ready = main_mem_in_valid && (next_rand() % 3 == 0);
			main_mem_out_ready = main_mem_out_valid && (next_rand() % 3 == 0);
			main_mem_out_data = mem_model[main_mem_out_addr[9:2]];
		end
	end

	// ====================
	// Checks
	// ====================
	a_quiet_start: assert property (@(negedge clk) disable iff (!rst_n)
		!issued_once |-> !completed && !main_mem_in_valid && !main_mem_out_valid)
		else protocol_error("activity before the first instruction");

	a_idle_silent: assert property (@(negedge clk) disable iff (!rst_n)
		(inst_num < 6'd4) |-> !completed)
		else protocol_error("completed raised while an idle number was presented");

	a_reg_result: assert property (@(negedge clk) disable iff (!rst_n)
		completed |-> exec_reg_out == exp_reg)
		else value_mismatch($sformatf("op %0d result %h, expected %h",
			$sampled(inst_num), $sampled(exec_reg_out), $sampled(exp_reg)));

	a_pc_result: assert property (@(negedge clk) disable iff (!rst_n)
		completed |-> exec_pc_out == exp_pc)
		else value_mismatch($sformatf("op %0d next pc %h, expected %h",
			$sampled(inst_num), $sampled(exec_pc_out), $sampled(exp_pc)));

	a_latency: assert property (@(negedge clk) disable iff (!rst_n)
		completed |-> ((exp_lat == 0) ? (cycles - issue_cyc >= 2)
		                              : (cycles - issue_cyc == exp_lat)))
		else value_mismatch($sformatf("op %0d completed after %0d cycles, expected %0d",
			$sampled(inst_num), $sampled(cycles) - $sampled(issue_cyc), $sampled(exp_lat)));

	a_store_port: assert property (@(negedge clk) disable iff (!rst_n)
		main_mem_in_valid |-> main_mem_in_addr == exp_addr && main_mem_in_data == exp_wdata)
		else value_mismatch($sformatf("store to %h with %h, expected %h with %h",
			$sampled(main_mem_in_addr), $sampled(main_mem_in_data),
			$sampled(exp_addr), $sampled(exp_wdata)));

	a_load_port: assert property (@(negedge clk) disable iff (!rst_n)
		main_mem_out_valid |-> main_mem_out_addr == exp_addr)
		else value_mismatch($sformatf("load from %h, expected %h",
			$sampled(main_mem_out_addr), $sampled(exp_addr)));

	a_valids_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(main_mem_in_valid && main_mem_out_valid))
		else protocol_error("store and load valid high together");

	a_store_held: assert property (@(posedge clk) disable iff (!rst_n)
		main_mem_in_valid && !main_mem_in_ready |=>
		main_mem_in_valid && $stable(main_mem_in_addr) && $stable(main_mem_in_data))
		else protocol_error("store request changed before ready");

	a_load_held: assert property (@(posedge clk) disable iff (!rst_n)
		main_mem_out_valid && !main_mem_out_ready |=>
		main_mem_out_valid && $stable(main_mem_out_addr))
		else protocol_error("load request changed before ready");

	// ====================
	// Stimulus
	// ====================
	initial begin
		int op;
		int k;
		int nop_list [8] = '{4, 5, 6, 7, 14, 15, 48, 63};
		logic [31:0] a;
		logic [31:0] data;
		logic [15:0] imm;
		rst_n = 1'b0;
		pc = '0;
		inst_num = '0;
		const16 = '0;
		shift5 = '0;
		addr26 = '0;
		rs = '0;
		rt = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		repeat (5) begin
			@(negedge clk);
			inst_num = 6'(next_rand() % 4);
		end
		finish_test("reset and idle");

		for (op = 8; op < 28; op++) begin
			if (op >= 12 && op < 16)
				continue;
			repeat (3)
				issue(6'(op), next_rand(), next_rand(), 16'(next_rand()),
					5'(next_rand()), 26'(next_rand()), rand_pc());
		end
		finish_test("alu operations");

		repeat (6)
			issue(OP_MUL, next_rand(), next_rand(), '0, '0, '0, rand_pc());
		repeat (6)
			issue(OP_DIVU, next_rand(), next_rand() >> (next_rand() % 32), '0, '0, '0,
				rand_pc());
		issue(OP_DIVU, next_rand(), '0, '0, '0, '0, rand_pc()); // Zero divisor.
		finish_test("multiply and divide");

		for (k = 0; k < 6; k++) begin
			a = next_rand();
			imm = 16'(next_rand() % 1024);
			data = next_rand();
			issue((k == 5) ? 6'd31 : OP_SW, a, data, imm, '0, '0, rand_pc());
			issue((k == 5) ? 6'd30 : OP_LW, a, next_rand(), imm, '0, '0, rand_pc());
		end
		finish_test("store and load");

		a = next_rand();
		imm = 16'(next_rand());
		issue(OP_BEQ, a, a, imm, '0, '0, rand_pc());
		issue(OP_BEQ, a, a ^ 32'd1, imm, '0, '0, rand_pc());
		issue(OP_BNE, a, a + 32'd1, imm, '0, '0, rand_pc());
		issue(OP_BNE, a, a, imm, '0, '0, rand_pc());
		issue(OP_J, a, a, imm, '0, 26'(next_rand()), rand_pc());
		issue(OP_JAL, a, a, imm, '0, 26'(next_rand()), rand_pc());
		issue(OP_JR, rand_pc(), a, imm, '0, '0, rand_pc());
		issue(6'd40, a, a, imm, '0, 26'(next_rand()), rand_pc());
		issue(6'd47, a, a, imm, '0, 26'(next_rand()), rand_pc());
		finish_test("branches and jumps");

		for (k = 0; k < 8; k++)
			issue(6'(nop_list[k]), next_rand(), next_rand(), 16'(next_rand()),
				5'(next_rand()), 26'(next_rand()), rand_pc());
		for (k = 0; k < 4; k++) begin
			@(negedge clk);
			inst_num = 6'(k);
			@(negedge clk);
		end
		finish_test("no-ops and idle");

		$display("Tests run: %0d, instructions: %0d, errors: %0d", n_tests, n_instr, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/step_counter.sv
rtl/alu_elem.sv
rtl/muldiv_elem.sv
rtl/mem_elem.sv
rtl/branch_elem.sv
rtl/exec_unit.sv
tb/exec_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module exec_unit_tb -f verilog.f -o exec_unit_tb_sim

output=$(./obj_dir/exec_unit_tb_sim)
echo "$output"

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
else
	exit 1
fi
